// ==== verilog/opm_noise_pkg.sv ====
package opm_noise_pkg;

    // ####################################################################
    // Host bus
    // ####################################################################

    // Data bus width of the two-step host interface
    localparam int BUS_W = 8;
    // Noise control register address
    localparam logic [BUS_W-1:0] NOISE_ADDR = 8'h0F;
    // Data bit carrying noise enable
    localparam int NE_BIT = 7;
    // Noise frequency field, low bits of the data byte
    localparam int NFRQ_W = 5;

    // ####################################################################
    // Slots and samples
    // ####################################################################

    // 32 operator slots per sample
    localparam int SLOT_W = 5;
    // Operator 31 carries the noise
    localparam logic [SLOT_W-1:0] LAST_SLOT = 5'd31;
    // Envelope attenuation width
    localparam int EG_W = 10;
    // Sample is sign plus magnitude
    localparam int OUT_W = EG_W + 1;

    // Noise shift register length and its seed
    localparam int LFSR_W = 17;
    localparam logic [LFSR_W-1:0] LFSR_INIT = 17'd90;

endpackage

// ==== verilog/opm_noise_regs.sv ====
`timescale 1ns/100ps

module opm_noise_regs (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr,
    input  logic                              a0,
    input  logic [opm_noise_pkg::BUS_W-1:0]   din,
    output logic                              ne,
    output logic [opm_noise_pkg::NFRQ_W-1:0]  nfrq
);

    // ####################################################################
    // Bus decode
    // ####################################################################

    // Latched register address
    logic [opm_noise_pkg::BUS_W-1:0] addr;

    // Address phase strobe
    logic addr_wr;
    // Data phase strobe
    logic data_wr;
    // Latched address points at noise control
    logic noise_sel;

    assign addr_wr   = wr & ~a0;
    assign data_wr   = wr & a0;
    assign noise_sel = (addr == opm_noise_pkg::NOISE_ADDR);

    // Address latch keeps its value across data writes
    // so a run of data writes lands in the same register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
        end else if (addr_wr) begin
            addr <= din;
        end
    end

    // ####################################################################
    // Noise control register
    // ####################################################################

    // Loaded only when the data phase hits the noise address
    // Writes to other addresses fall through untouched
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ne   <= 1'b0;
            nfrq <= '0;
        end else if (data_wr && noise_sel) begin
            // Enable from the top bit
            ne   <= din[opm_noise_pkg::NE_BIT];
            // Frequency from the low five bits
            nfrq <= din[opm_noise_pkg::NFRQ_W-1:0];
        end
    end

endmodule

// ==== verilog/opm_slot_seq.sv ====
`timescale 1ns/100ps

module opm_slot_seq (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic op31,
    output logic smp
);

    // ####################################################################
    // Slot counter
    // ####################################################################

    // Current operator slot
    logic [opm_noise_pkg::SLOT_W-1:0] slot;

    // One slot per clock enable
    // wraps back to slot 0 after operator 31
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= '0;
        end else if (cen) begin
            if (slot == opm_noise_pkg::LAST_SLOT) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // Level flag for the noise slot
    // No register here so the noise block sees it in the same cycle
    assign op31 = (slot == opm_noise_pkg::LAST_SLOT);

    // ####################################################################
    // Sample pulse
    // ####################################################################

    // Registered on the same edge that loads the noise sample
    // One pulse every 32 enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            smp <= 1'b0;
        end else begin
            smp <= cen & op31;
        end
    end

endmodule

// ==== verilog/opm_noise_lfsr.sv ====
`timescale 1ns/100ps

module opm_noise_lfsr (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  logic base,
    output logic sign
);

    // ####################################################################
    // Noise shift register
    // ####################################################################

    // 17 stages, shifting toward bit 0
    logic [opm_noise_pkg::LFSR_W-1:0] lfsr;

    // Feedback into the top stage
    logic fb;

    // Inverted XOR of taps 0 and 3
    // the inversion keeps an all-zero state from locking up
    assign fb = ~(lfsr[0] ^ lfsr[3]);

    // Seeded at reset, never cleared afterwards
    // Advances once per base pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= opm_noise_pkg::LFSR_INIT;
        end else if (cen && base) begin
            lfsr <= {fb, lfsr[opm_noise_pkg::LFSR_W-1:1]};
        end
    end

    // ####################################################################
    // Output
    // ####################################################################

    // Random sign taken from the bottom stage
    // A sample formed on the base edge still sees the state before the shift
    assign sign = lfsr[0];

endmodule

// ==== verilog/opm_noise.sv ====
`timescale 1ns/100ps

module opm_noise (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              op31,
    input  logic                              ne,
    input  logic [opm_noise_pkg::NFRQ_W-1:0]  nfrq,
    input  logic [opm_noise_pkg::EG_W-1:0]    eg,
    output logic [opm_noise_pkg::OUT_W-1:0]   out
);

    // ####################################################################
    // Rate divider
    // ####################################################################

    // Divider counter, one bit narrower than nfrq
    logic [opm_noise_pkg::NFRQ_W-2:0] cnt;
    // Shift request for the LFSR
    logic                             base;
    // Random sign from the LFSR
    logic                             sign;

    // Active step of the noise slot
    logic step;
    // Counter at its last state
    logic cnt_full;

    assign step     = cen & op31 & ne;
    assign cnt_full = &cnt;

    // Counts slot-31 steps and reloads from nfrq on overflow
    // nfrq[0] gives no extra resolution
    // nfrq 31 trips every sample, nfrq 0 and 1 every 16 samples
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (step) begin
            if (cnt_full) begin
                cnt <= nfrq[opm_noise_pkg::NFRQ_W-1:1];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Base is a single enable wide
    // raised on an overflowing step and dropped on the next enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            base <= 1'b0;
        end else if (cen) begin
            base <= step & cnt_full;
        end
    end

    // ####################################################################
    // Random source
    // ####################################################################

    opm_noise_lfsr u_lfsr (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .base (base),
        .sign (sign)
    );

    // ####################################################################
    // Sample former
    // ####################################################################

    // Sign on top, attenuation flipped when the sign is low
    // Parked at zero while noise is disabled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else if (cen && op31) begin
            if (ne) begin
                out <= {sign, {opm_noise_pkg::EG_W{~sign}} ^ eg};
            end else begin
                out <= '0;
            end
        end
    end

endmodule

// ==== verilog/opm_noise_top.sv ====
`timescale 1ns/100ps

module opm_noise_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen,
    input  logic                              wr,
    input  logic                              a0,
    input  logic [opm_noise_pkg::BUS_W-1:0]   din,
    input  logic [opm_noise_pkg::EG_W-1:0]    eg,
    output logic [opm_noise_pkg::OUT_W-1:0]   out,
    output logic                              smp
);

    // ####################################################################
    // Internal wiring
    // ####################################################################

    // Noise control from the register block
    logic                             ne;
    logic [opm_noise_pkg::NFRQ_W-1:0] nfrq;

    // Noise slot flag from the sequencer
    logic                             op31;

    // ####################################################################
    // Host registers
    // ####################################################################

    // Address write then data write
    opm_noise_regs u_regs (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .a0   (a0),
        .din  (din),
        .ne   (ne),
        .nfrq (nfrq)
    );

    // ####################################################################
    // Slot sequencer
    // ####################################################################

    // Walks the 32 slots and flags operator 31
    // smp leaves on the same edge as out
    opm_slot_seq u_seq (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .op31 (op31),
        .smp  (smp)
    );

    // ####################################################################
    // Noise generator
    // ####################################################################

    // eg belongs to operator 31 and is sampled on its enable
    opm_noise u_noise (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .op31 (op31),
        .ne   (ne),
        .nfrq (nfrq),
        .eg   (eg),
        .out  (out)
    );

endmodule

// ==== sim/tb_opm_noise.sv ====
`timescale 1ns/100ps

module tb_opm_noise;

    // Clocks allowed per sample pulse
    // One sample takes 64 clocks
    localparam int SMP_WAIT = 200;

    // ####################################################################
    // Signals
    // ####################################################################

    // DUT inputs
    logic                              clk = 1'b0;
    logic                              rst;
    logic                              cen;
    logic                              wr;
    logic                              a0;
    logic [opm_noise_pkg::BUS_W-1:0]   din;
    logic [opm_noise_pkg::EG_W-1:0]    eg;

    // DUT outputs
    logic [opm_noise_pkg::OUT_W-1:0]   out;
    logic                              smp;

    // Random source
    integer      seed = 32'h6ee1;
    logic [31:0] rnd_eg;
    logic [31:0] rnd_frq;

    // Model of the host registers
    logic [opm_noise_pkg::BUS_W-1:0]   addr_m;
    logic                              ne_m;
    logic [opm_noise_pkg::NFRQ_W-1:0]  nfrq_m;

    // Model of sequencer, divider and LFSR
    logic [opm_noise_pkg::SLOT_W-1:0]  slot_m;
    logic [opm_noise_pkg::NFRQ_W-2:0]  cnt_m;
    logic [opm_noise_pkg::LFSR_W-1:0]  lfsr_m;

    // Expected values valid from the edge that loads the sample
    logic                              exp_smp;
    logic [opm_noise_pkg::OUT_W-1:0]   exp_out;
    logic [opm_noise_pkg::EG_W-1:0]    eg_s;
    logic                              ne_s;
    logic                              sign_s;

    // Error counters
    int   err_smp = 0;
    int   err_out = 0;
    int   err_zero = 0;
    int   err_mag = 0;
    int   err_sign = 0;
    int   err_timeout = 0;
    int   n_shift = 0;
    logic timed_out = 1'b0;

    // ####################################################################
    // DUT
    // ####################################################################

    opm_noise_top DUT (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .wr   (wr),
        .a0   (a0),
        .din  (din),
        .eg   (eg),
        .out  (out),
        .smp  (smp)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // cen on every second clock and a fresh eg on every clock
    always @(negedge clk) begin
        cen = ~cen;
        rnd_eg = $random(seed);
        eg = rnd_eg[opm_noise_pkg::EG_W-1:0];
    end

    // ####################################################################
    // Reference model
    // ####################################################################

    // One noise step with the inverted XOR of bits 0 and 3 entering at the top
    function automatic logic [opm_noise_pkg::LFSR_W-1:0] lfsr_step(
        input logic [opm_noise_pkg::LFSR_W-1:0] s
    );
        return {~(s[0] ^ s[3]), s[opm_noise_pkg::LFSR_W-1:1]};
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_m  <= '0;
            ne_m    <= 1'b0;
            nfrq_m  <= '0;
            slot_m  <= '0;
            cnt_m   <= '0;
            lfsr_m  <= opm_noise_pkg::LFSR_INIT;
            exp_smp <= 1'b0;
            exp_out <= '0;
            eg_s    <= '0;
            ne_s    <= 1'b0;
            sign_s  <= 1'b0;
        end else begin
            // Address phase then data phase into noise control only
            if (wr && !a0) begin
                addr_m <= din;
            end
            if (wr && a0 && addr_m == opm_noise_pkg::NOISE_ADDR) begin
                ne_m   <= din[opm_noise_pkg::NE_BIT];
                nfrq_m <= din[opm_noise_pkg::NFRQ_W-1:0];
            end
            exp_smp <= cen && (slot_m == opm_noise_pkg::LAST_SLOT);
            if (cen) begin
                slot_m <= slot_m + 1'b1;
                // Noise slot forms the sample
                if (slot_m == opm_noise_pkg::LAST_SLOT) begin
                    eg_s   <= eg;
                    ne_s   <= ne_m;
                    sign_s <= lfsr_m[0];
                    if (ne_m) begin
                        exp_out <= {lfsr_m[0], eg ^ {opm_noise_pkg::EG_W{~lfsr_m[0]}}};
                        // Overflow reloads and schedules one shift before the next sample
                        if (&cnt_m) begin
                            cnt_m   <= nfrq_m[opm_noise_pkg::NFRQ_W-1:1];
                            lfsr_m  <= lfsr_step(lfsr_m);
                            n_shift <= n_shift + 1;
                        end else begin
                            cnt_m <= cnt_m + 1'b1;
                        end
                    end else begin
                        exp_out <= '0;
                    end
                end
            end
        end
    end

    // ####################################################################
    // Checks
    // ####################################################################

    // Pulse position 32 enables apart
    smp_timing: assert property (@(posedge clk) disable iff (rst) smp == exp_smp)
        else begin
            $display("ERR smp exp=%h got=%h", $sampled(exp_smp), $sampled(smp));
            err_smp++;
        end

    // Whole sample against the model
    // Held between pulses too
    out_value: assert property (@(posedge clk) disable iff (rst) out == exp_out)
        else begin
            $display("ERR out exp=%h got=%h", $sampled(exp_out), $sampled(out));
            err_out++;
        end

    // Noise off parks the output
    out_parked: assert property (@(posedge clk) disable iff (rst) (smp && !ne_s) |-> out == '0)
        else begin
            $display("ERR out exp=%h got=%h", 11'h000, $sampled(out));
            err_zero++;
        end

    // Magnitude follows eg and flips when the sign is low
    out_mag: assert property (@(posedge clk) disable iff (rst)
        (smp && ne_s) |->
        out[opm_noise_pkg::EG_W-1:0] == (eg_s ^ {opm_noise_pkg::EG_W{~out[opm_noise_pkg::EG_W]}}))
        else begin
            $display("ERR out[9:0] exp=%h got=%h",
                     $sampled(eg_s ^ {opm_noise_pkg::EG_W{~out[opm_noise_pkg::EG_W]}}),
                     $sampled(out[opm_noise_pkg::EG_W-1:0]));
            err_mag++;
        end

    // Sign bit is the model LFSR output
    out_sign: assert property (@(posedge clk) disable iff (rst)
        (smp && ne_s) |-> out[opm_noise_pkg::EG_W] == sign_s)
        else begin
            $display("ERR out[10] exp=%h got=%h", $sampled(sign_s),
                     $sampled(out[opm_noise_pkg::EG_W]));
            err_sign++;
        end

    // ####################################################################
    // Stimulus tasks
    // ####################################################################

    task automatic set_address(input logic [opm_noise_pkg::BUS_W-1:0] a);
        @(negedge clk);
        wr  = 1'b1;
        a0  = 1'b0;
        din = a;
        @(negedge clk);
        wr  = 1'b0;
    endtask

    task automatic put_data(input logic [opm_noise_pkg::BUS_W-1:0] d);
        @(negedge clk);
        wr  = 1'b1;
        a0  = 1'b1;
        din = d;
        @(negedge clk);
        wr  = 1'b0;
    endtask

    // Control byte from enable and frequency
    function automatic logic [opm_noise_pkg::BUS_W-1:0] noise_byte(
        input logic                             en,
        input logic [opm_noise_pkg::NFRQ_W-1:0] f
    );
        logic [opm_noise_pkg::BUS_W-1:0] b;
        b = '0;
        b[opm_noise_pkg::NE_BIT] = en;
        b[opm_noise_pkg::NFRQ_W-1:0] = f;
        return b;
    endfunction

    task automatic program_noise(input logic en, input logic [opm_noise_pkg::NFRQ_W-1:0] f);
        set_address(opm_noise_pkg::NOISE_ADDR);
        put_data(noise_byte(en, f));
    endtask

    // Each pulse gets its own bounded wait
    task automatic wait_samples(input int n);
        int i;
        int cyc;
        i = 0;
        while (i < n && !timed_out) begin
            cyc = 0;
            @(negedge clk);
            while (!smp && cyc < SMP_WAIT) begin
                @(negedge clk);
                cyc++;
            end
            if (smp) begin
                i++;
            end else begin
                $display("Timeout: no sample pulse within %0d clocks", SMP_WAIT);
                err_timeout++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        int total;
        total = err_smp + err_out + err_zero + err_mag + err_sign + err_timeout;
        $display("Errors: smp=%0d out=%0d zero=%0d mag=%0d sign=%0d timeout=%0d shifts=%0d",
                 err_smp, err_out, err_zero, err_mag, err_sign, err_timeout, n_shift);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // ####################################################################
    // Test sequence
    // ####################################################################

    initial begin
        // nfrq for the random rate run
        rnd_frq = $random(seed);
        rst = 1'b1;
        cen = 1'b0;
        wr  = 1'b0;
        a0  = 1'b0;
        din = '0;
        eg  = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // Idle after reset with noise off
        wait_samples(4);

        // Fastest rate with one shift per sample
        program_noise(1'b1, 5'd31);
        wait_samples(24);
        // Slowest rate with one shift per 16 samples
        program_noise(1'b1, 5'd0);
        wait_samples(40);
        // Random rate
        program_noise(1'b1, rnd_frq[opm_noise_pkg::NFRQ_W-1:0]);
        wait_samples(40);

        // Data write under a foreign address is dropped
        set_address(8'h20);
        put_data(noise_byte(1'b0, 5'd3));
        wait_samples(8);

        // Address latch persists across data writes
        program_noise(1'b1, 5'd27);
        wait_samples(12);
        put_data(noise_byte(1'b0, 5'd27));
        wait_samples(6);

        finish_run();
    end

endmodule

// ==== opm_noise.f ====
verilog/opm_noise_pkg.sv
verilog/opm_noise_regs.sv
verilog/opm_slot_seq.sv
verilog/opm_noise_lfsr.sv
verilog/opm_noise.sv
verilog/opm_noise_top.sv
sim/tb_opm_noise.sv

// ==== Makefile ====
# Verilator build and run for the OPM noise section
# Every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_opm_noise
RTL_TOP   ?= opm_noise_top
FILELIST  ?= opm_noise.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --assert
LINTFLAGS ?= --lint-only --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the exit code of the model
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
